// File: verilog/emif_pll_macros.svh
// Counter count, lock time, queue depth and reset divide values of the PLL output stage
`ifndef EMIF_PLL_MACROS_SVH
`define EMIF_PLL_MACROS_SVH

////////////////////////////////////////////////////////////
// Output counter bank
////////////////////////////////////////////////////////////

// Number of C-counters that are modelled (counters 5 to 8 are not used)
`define EMIF_PLL_NUM_C_COUNTERS 5

// Divide counts that every counter takes out of reset
// A counter runs high for the high count and low for the low count
`define EMIF_PLL_DEFAULT_HIGH 2
`define EMIF_PLL_DEFAULT_LOW 2

////////////////////////////////////////////////////////////
// Lock and reconfiguration
////////////////////////////////////////////////////////////

// VCO cycles from reset release until the PLL reports lock
// This must fit the five-bit lock counter
`define EMIF_PLL_LOCK_CYCLES 31

// Entries in the command queue between decoder and counter bank
`define EMIF_PLL_QUEUE_DEPTH 4

`endif

// File: verilog/emif_pll_pkg.sv
// Command opcode, phase and divide views of a reconfiguration word, and their union
`default_nettype none

package emif_pll_pkg;

   // Opcode in the top bit of every command word
   typedef enum logic {
      op_phase  = 1'b0,
      op_divide = 1'b1
   } cfg_op_e;

   // Phase view of a command word
   // Up_dn set delays the selected output, clear advances it
   typedef struct packed {
      cfg_op_e    op;
      logic [2:0] cnt_sel;
      logic       up_dn;
      logic [2:0] num_shifts;
      logic [7:0] reserved;
   } cfg_phase_t;

   // Divide view of a command word
   // Both counts must be nonzero for a legal command
   typedef struct packed {
      cfg_op_e    op;
      logic [2:0] cnt_sel;
      logic [5:0] high_count;
      logic [5:0] low_count;
   } cfg_divide_t;

   // Op and cnt_sel sit at the same bits in both views
   // So either view can be read before the opcode is known
   typedef union packed {
      cfg_phase_t  phase;
      cfg_divide_t divide;
   } cfg_word_u;

endpackage

`default_nettype wire

// File: verilog/pll_lock_detect.sv
// Lock detector that raises pll_locked a fixed number of VCO cycles after reset
`timescale 1ns/1ns
`default_nettype none

`include "emif_pll_macros.svh"

module pll_lock_detect (
   input  logic vco_out,
   input  logic global_reset_n_int,
   output logic pll_locked
);

   // Counts VCO edges since reset release
   logic [4:0] lock_count;

   ////////////////////////////////////////////////////////////
   // Saturating lock counter
   ////////////////////////////////////////////////////////////

   // The counter stops at the lock value and holds there until the next reset
   always_ff @(posedge vco_out or negedge global_reset_n_int) begin
      if (!global_reset_n_int) begin
         lock_count <= 5'd0;
      end else if (lock_count != 5'(`EMIF_PLL_LOCK_CYCLES)) begin
         lock_count <= lock_count + 5'd1;
      end
   end

   // Lock is reported from the first cycle after the last counted edge
   assign pll_locked = (lock_count == 5'(`EMIF_PLL_LOCK_CYCLES));

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Once locked the PLL stays locked for as long as reset is released
   a_lock_holds : assert property (
      @(posedge vco_out) disable iff (!global_reset_n_int)
      pll_locked |=> pll_locked
   );

endmodule

`default_nettype wire

// File: verilog/pll_reconfig_decoder.sv
// Reconfiguration decoder that checks command words and pushes legal ones into the queue
`timescale 1ns/1ns
`default_nettype none

`include "emif_pll_macros.svh"

module pll_reconfig_decoder (
   input  logic                    vco_out,
   input  logic                    global_reset_n_int,
   input  logic                    cfg_valid,
   input  emif_pll_pkg::cfg_word_u cfg_word,
   input  logic                    full,
   output logic                    push,
   output emif_pll_pkg::cfg_word_u push_word,
   output logic                    cfg_error,
   output logic                    cfg_overflow
);
   import emif_pll_pkg::*;

   // Field checks on the incoming word
   logic sel_ok;
   logic count_ok;
   logic legal;
   logic accept;

   ////////////////////////////////////////////////////////////
   // Field checks
   ////////////////////////////////////////////////////////////

   // Only counters 0 to 4 exist, whatever the opcode
   assign sel_ok = (cfg_word.phase.cnt_sel < 3'(`EMIF_PLL_NUM_C_COUNTERS));

   // A divide needs both counts nonzero
   // A phase command has no count to check, any shift count is accepted
   always_comb begin
      count_ok = 1'b1;
      if (cfg_word.phase.op == op_divide) begin
         count_ok = (cfg_word.divide.high_count != 6'd0) &&
                    (cfg_word.divide.low_count != 6'd0);
      end
   end

   assign legal = sel_ok && count_ok;

   // Legal words go to the queue unless it has no room left
   assign accept = cfg_valid && legal && !full;

   ////////////////////////////////////////////////////////////
   // Registered result
   ////////////////////////////////////////////////////////////

   // Each strobe gives exactly one of push, error or overflow on the next cycle
   // An error takes priority over a full queue
   always_ff @(posedge vco_out or negedge global_reset_n_int) begin
      if (!global_reset_n_int) begin
         push         <= 1'b0;
         cfg_error    <= 1'b0;
         cfg_overflow <= 1'b0;
      end else begin
         push         <= accept;
         cfg_error    <= cfg_valid && !legal;
         cfg_overflow <= cfg_valid && legal && full;
      end
   end

   // The word itself is only meaningful while push is high
   always_ff @(posedge vco_out) begin
      if (accept) begin
         push_word <= cfg_word;
      end
   end

endmodule

`default_nettype wire

// File: verilog/pll_reconfig_queue.sv
// Four-entry FIFO of reconfiguration command words
`timescale 1ns/1ns
`default_nettype none

`include "emif_pll_macros.svh"

module pll_reconfig_queue (
   input  logic                    vco_out,
   input  logic                    global_reset_n_int,
   input  logic                    push,
   input  emif_pll_pkg::cfg_word_u push_word,
   input  logic                    pop,
   output emif_pll_pkg::cfg_word_u head_word,
   output logic                    empty,
   output logic                    full
);
   import emif_pll_pkg::*;

   // Storage and pointers
   cfg_word_u                                  mem [`EMIF_PLL_QUEUE_DEPTH];
   logic [$clog2(`EMIF_PLL_QUEUE_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(`EMIF_PLL_QUEUE_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(`EMIF_PLL_QUEUE_DEPTH+1)-1:0] count;
   logic [$clog2(`EMIF_PLL_QUEUE_DEPTH+1)-1:0] count_nxt;

   ////////////////////////////////////////////////////////////
   // Occupancy
   ////////////////////////////////////////////////////////////

   // Occupancy after this edge, with the push and pop now on the wires
   always_comb begin
      count_nxt = count;
      if (push && !pop) begin
         count_nxt = count + 1'b1;
      end else if (pop && !push) begin
         count_nxt = count - 1'b1;
      end
   end

   // The decoder registers its push, so a word it accepts now lands one edge later
   // Full therefore looks at the occupancy after the push already in flight
   assign full  = (count_nxt == `EMIF_PLL_QUEUE_DEPTH);
   assign empty = (count == '0);

   // Head of the queue, valid whenever empty is low
   assign head_word = mem[rd_ptr];

   ////////////////////////////////////////////////////////////
   // Pointers and storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge vco_out or negedge global_reset_n_int) begin
      if (!global_reset_n_int) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == `EMIF_PLL_QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == `EMIF_PLL_QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         count <= count_nxt;
      end
   end

   always_ff @(posedge vco_out) begin
      if (push) begin
         mem[wr_ptr] <= push_word;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // The decoder must never push into a queue that holds all its entries
   a_no_push_full : assert property (
      @(posedge vco_out) disable iff (!global_reset_n_int)
      push |-> (count != `EMIF_PLL_QUEUE_DEPTH)
   );

   // The counter bank must never pop an empty queue
   a_no_pop_empty : assert property (
      @(posedge vco_out) disable iff (!global_reset_n_int)
      pop |-> !empty
   );

endmodule

`default_nettype wire

// File: verilog/pll_counter_bank.sv
// Bank of five C-counters with divide reprogramming and dynamic phase shift
`timescale 1ns/1ns
`default_nettype none

`include "emif_pll_macros.svh"

module pll_counter_bank (
   input  logic                                 vco_out,
   input  logic                                 global_reset_n_int,
   input  logic                                 pll_locked,
   input  emif_pll_pkg::cfg_word_u              head_word,
   input  logic                                 empty,
   output logic                                 pop,
   output logic [`EMIF_PLL_NUM_C_COUNTERS-1:0]  pll_c_counters,
   output logic                                 pll_phase_done
);
   import emif_pll_pkg::*;

   // Phase shift in progress
   logic [2:0] shift_left;
   logic [2:0] shift_sel;
   logic       shift_up;
   logic       shift_busy;

   // Common fields of the word at the head of the queue
   logic       head_is_divide;
   logic [2:0] head_sel;

   ////////////////////////////////////////////////////////////
   // Command fetch
   ////////////////////////////////////////////////////////////

   // Op and cnt_sel are common to both views, read them through the phase view
   assign head_is_divide = (head_word.phase.op == op_divide);
   assign head_sel       = head_word.phase.cnt_sel;

   // The done cycle still counts as busy
   // so a zero-step command right behind cannot pulse done twice in a row
   assign shift_busy = (shift_left != 3'd0) || pll_phase_done;

   // Words wait in the queue until lock, then leave one per cycle
   assign pop = pll_locked && !empty && !shift_busy;

   ////////////////////////////////////////////////////////////
   // Phase shift sequencer
   ////////////////////////////////////////////////////////////

   // One step per cycle, done pulses in the cycle after the last step
   always_ff @(posedge vco_out or negedge global_reset_n_int) begin
      if (!global_reset_n_int) begin
         shift_left     <= 3'd0;
         shift_sel      <= 3'd0;
         shift_up       <= 1'b0;
         pll_phase_done <= 1'b0;
      end else if (shift_left != 3'd0) begin
         shift_left     <= shift_left - 3'd1;
         pll_phase_done <= (shift_left == 3'd1);
      end else if (pop && !head_is_divide) begin
         shift_left     <= head_word.phase.num_shifts;
         shift_sel      <= head_sel;
         shift_up       <= head_word.phase.up_dn;
         // no steps to take, so report done right away
         pll_phase_done <= (head_word.phase.num_shifts == 3'd0);
      end else begin
         pll_phase_done <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Output counters
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < `EMIF_PLL_NUM_C_COUNTERS; i++) begin : g_cnt
      logic [5:0] pend_high;
      logic [5:0] pend_low;
      logic [5:0] act_high;
      logic [5:0] act_low;
      logic [6:0] pos;
      logic [6:0] period;
      logic [6:0] pos_sum;
      logic [1:0] inc;
      logic       wrap;
      logic       load;

      // A divide for this counter only updates the pending counts
      assign load = pop && head_is_divide && (head_sel == 3'(i));

      // Normal step is one, a delay step holds, an advance step jumps by two
      always_comb begin
         inc = 2'd1;
         if ((shift_left != 3'd0) && (shift_sel == 3'(i))) begin
            inc = shift_up ? 2'd0 : 2'd2;
         end
      end

      // Period is at most 126, so the sum fits in seven bits
      assign period  = {1'b0, act_high} + {1'b0, act_low};
      assign pos_sum = pos + {5'd0, inc};
      assign wrap    = (pos_sum >= period);

      always_ff @(posedge vco_out or negedge global_reset_n_int) begin
         if (!global_reset_n_int) begin
            pos       <= 7'd0;
            pend_high <= 6'(`EMIF_PLL_DEFAULT_HIGH);
            pend_low  <= 6'(`EMIF_PLL_DEFAULT_LOW);
            act_high  <= 6'(`EMIF_PLL_DEFAULT_HIGH);
            act_low   <= 6'(`EMIF_PLL_DEFAULT_LOW);
         end else begin
            if (load) begin
               pend_high <= head_word.divide.high_count;
               pend_low  <= head_word.divide.low_count;
            end
            // Position stays at zero until lock, so all counters start in step
            if (pll_locked) begin
               if (wrap) begin
                  // New counts take effect on the wrap, which is the next rising edge
                  pos      <= pos_sum - period;
                  act_high <= pend_high;
                  act_low  <= pend_low;
               end else begin
                  pos <= pos_sum;
               end
            end
         end
      end

      // High for the first high_count positions of each period
      assign pll_c_counters[i] = pll_locked && (pos < {1'b0, act_high});
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Each phase command reports done with a single one-cycle pulse
   a_done_pulse : assert property (
      @(posedge vco_out) disable iff (!global_reset_n_int)
      pll_phase_done |=> !pll_phase_done
   );

endmodule

`default_nettype wire

// File: verilog/emif_pll_top.sv
// Top level of the PLL output stage with lock detector, decoder, queue and counter bank
`timescale 1ns/1ns
`default_nettype none

`include "emif_pll_macros.svh"

module emif_pll_top (
   input  logic                                vco_out,
   input  logic                                global_reset_n_int,
   input  logic                                cfg_valid,
   input  emif_pll_pkg::cfg_word_u             cfg_word,
   output logic                                pll_locked,
   output logic [`EMIF_PLL_NUM_C_COUNTERS-1:0] pll_c_counters,
   output logic                                pll_phase_done,
   output logic                                cfg_error,
   output logic                                cfg_overflow
);
   import emif_pll_pkg::*;

   // Decoder to queue
   logic      push;
   cfg_word_u push_word;
   logic      full;

   // Queue to counter bank
   logic      pop;
   logic      empty;
   cfg_word_u head_word;

   ////////////////////////////////////////////////////////////
   // Lock and command path
   ////////////////////////////////////////////////////////////

   pll_lock_detect u_lock_detect (
      .vco_out            (vco_out),
      .global_reset_n_int (global_reset_n_int),
      .pll_locked         (pll_locked)
   );

   // Checks each strobed word, legal ones go to the queue
   pll_reconfig_decoder u_decoder (
      .vco_out            (vco_out),
      .global_reset_n_int (global_reset_n_int),
      .cfg_valid          (cfg_valid),
      .cfg_word           (cfg_word),
      .full               (full),
      .push               (push),
      .push_word          (push_word),
      .cfg_error          (cfg_error),
      .cfg_overflow       (cfg_overflow)
   );

   // Holds commands until the bank is locked and idle
   pll_reconfig_queue u_queue (
      .vco_out            (vco_out),
      .global_reset_n_int (global_reset_n_int),
      .push               (push),
      .push_word          (push_word),
      .pop                (pop),
      .head_word          (head_word),
      .empty              (empty),
      .full               (full)
   );

   ////////////////////////////////////////////////////////////
   // Output counters
   ////////////////////////////////////////////////////////////

   pll_counter_bank u_counter_bank (
      .vco_out            (vco_out),
      .global_reset_n_int (global_reset_n_int),
      .pll_locked         (pll_locked),
      .head_word          (head_word),
      .empty              (empty),
      .pop                (pop),
      .pll_c_counters     (pll_c_counters),
      .pll_phase_done     (pll_phase_done)
   );

endmodule

`default_nettype wire

// File: testbench/emif_pll_tb.sv
// Testbench for the PLL output stage with clock, reset, watchdog, directed tests and checks
`timescale 1ns/1ns
`default_nettype none

`include "emif_pll_macros.svh"

module emif_pll_tb;
   import emif_pll_pkg::*;

   localparam int clk_period    = 100;
   localparam int reset_cycles  = 8;
   localparam int n_cnt         = `EMIF_PLL_NUM_C_COUNTERS;
   localparam int def_high      = `EMIF_PLL_DEFAULT_HIGH;
   localparam int def_low       = `EMIF_PLL_DEFAULT_LOW;
   localparam int def_period    = def_high + def_low;
   // Rough sum of all test lengths in VCO cycles, and the slack on top of it
   localparam int test_cycles   = 460;
   localparam int margin_cycles = 240;

   logic             vco_out;
   logic             global_reset_n_int;
   logic             cfg_valid;
   cfg_word_u        cfg_word;
   logic             pll_locked;
   logic [n_cnt-1:0] pll_c_counters;
   logic             pll_phase_done;
   logic             cfg_error;
   logic             cfg_overflow;

   int   value_errors = 0;
   int   other_errors = 0;
   // Falling edges seen since lock, 0 on the first locked one
   int   lock_age     = 0;
   logic was_locked   = 1'b0;
   // Counters picked by the divide and phase tests
   int   div_sel;
   int   div_high;
   int   div_low;
   int   ph_sel;
   int   ref_sel;
   int   exp_delay;

   emif_pll_top u_emif_pll_top (
      .vco_out            (vco_out),
      .global_reset_n_int (global_reset_n_int),
      .cfg_valid          (cfg_valid),
      .cfg_word           (cfg_word),
      .pll_locked         (pll_locked),
      .pll_c_counters     (pll_c_counters),
      .pll_phase_done     (pll_phase_done),
      .cfg_error          (cfg_error),
      .cfg_overflow       (cfg_overflow)
   );

   initial begin
      vco_out = 1'b0;
      forever #(clk_period / 2) vco_out = ~vco_out;
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         value_errors++;
         $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      end
   endtask

   task automatic check_counters(input string name, input logic [n_cnt-1:0] actual,
                                 input logic [n_cnt-1:0] expected);
      if (actual !== expected) begin
         value_errors++;
         $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      end
   endtask

   // Period is high plus low time, and the high time is checked on its own as well
   task automatic check_period(input string name, input int meas_high, input int meas_low,
                               input int exp_high, input int exp_low);
      if (meas_high + meas_low != exp_high + exp_low) begin
         value_errors++;
         $display("Error at %0t ns: %s period is %0d cycles, expected %0d", $time, name,
                  meas_high + meas_low, exp_high + exp_low);
      end
      if (meas_high != exp_high) begin
         value_errors++;
         $display("Error at %0t ns: %s high time is %0d cycles, expected %0d", $time, name,
                  meas_high, exp_high);
      end
   endtask

   task automatic check_delay(input string name, input int actual, input int expected);
      if (actual != expected) begin
         value_errors++;
         $display("Error at %0t ns: %s is %0d cycles, expected %0d", $time, name, actual,
                  expected);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // Level of an untouched counter, counted from the first cycle of lock
   function automatic logic default_level(input int age);
      return (age % def_period) < def_high;
   endfunction

   function automatic cfg_word_u divide_word(input int sel, input int high, input int low);
      cfg_word_u w;
      w.divide.op         = op_divide;
      w.divide.cnt_sel    = 3'(sel);
      w.divide.high_count = 6'(high);
      w.divide.low_count  = 6'(low);
      return w;
   endfunction

   function automatic cfg_word_u phase_word(input int sel, input logic up, input int steps);
      cfg_word_u w;
      w.phase.op         = op_phase;
      w.phase.cnt_sel    = 3'(sel);
      w.phase.up_dn      = up;
      w.phase.num_shifts = 3'(steps);
      w.phase.reserved   = 8'h00;
      return w;
   endfunction

   // Reset goes low at once and is released on a falling edge
   task automatic apply_reset();
      global_reset_n_int = 1'b0;
      repeat (reset_cycles) @(negedge vco_out);
      global_reset_n_int = 1'b1;
   endtask

   // One-cycle strobe; returns on the falling edge where the decoder result is visible
   task automatic send_cmd(input cfg_word_u w);
      cfg_word  = w;
      cfg_valid = 1'b1;
      @(negedge vco_out);
      cfg_valid = 1'b0;
   endtask

   task automatic wait_phase_done();
      int n;
      n = 0;
      while (pll_phase_done !== 1'b1 && n < 20) begin
         @(negedge vco_out);
         n++;
      end
      if (pll_phase_done !== 1'b1) begin
         other_errors++;
         $display("pll_phase_done did not pulse after a phase command at %0t ns", $time);
      end else begin
         @(negedge vco_out);
         check_bit("pll_phase_done", pll_phase_done, 1'b0);
      end
   endtask

   // Waits for a fresh rising edge of one counter, then times a whole period
   task automatic measure_counter(input int idx, output int high_t, output int low_t);
      @(negedge vco_out);
      while (pll_c_counters[idx] !== 1'b0) @(negedge vco_out);
      while (pll_c_counters[idx] !== 1'b1) @(negedge vco_out);
      high_t = 0;
      while (pll_c_counters[idx] === 1'b1) begin
         high_t++;
         @(negedge vco_out);
      end
      low_t = 0;
      while (pll_c_counters[idx] === 1'b0) begin
         low_t++;
         @(negedge vco_out);
      end
   endtask

   // Cycles from a rising edge of the reference counter to the next one of sel
   task automatic rise_delay(input int sel, input int ref_idx, output int d);
      logic [n_cnt-1:0] prev;
      logic [n_cnt-1:0] cur;
      @(negedge vco_out);
      cur = pll_c_counters;
      do begin
         prev = cur;
         @(negedge vco_out);
         cur = pll_c_counters;
      end while (!(cur[ref_idx] && !prev[ref_idx]));
      d = 0;
      while (!(cur[sel] && !prev[sel])) begin
         prev = cur;
         @(negedge vco_out);
         cur = pll_c_counters;
         d++;
      end
   endtask

   // Tracks the lock age and flags any loss of lock while reset is released
   always @(negedge vco_out) begin
      if (global_reset_n_int && was_locked) begin
         check_bit("pll_locked", pll_locked, 1'b1);
      end
      was_locked <= global_reset_n_int && pll_locked;
      if (!global_reset_n_int || !pll_locked) begin
         lock_age <= 0;
      end else begin
         lock_age <= lock_age + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   // Outputs stay quiet until the lock edge, then every counter starts high
   task automatic lock_after_reset();
      for (int i = 1; i < `EMIF_PLL_LOCK_CYCLES; i++) begin
         @(negedge vco_out);
         check_bit("pll_locked", pll_locked, 1'b0);
         check_counters("pll_c_counters", pll_c_counters, '0);
      end
      @(negedge vco_out);
      check_bit("pll_locked", pll_locked, 1'b1);
      check_counters("pll_c_counters", pll_c_counters, '1);
   endtask

   task automatic default_division();
      repeat (4 * def_period) begin
         @(negedge vco_out);
         check_counters("pll_c_counters", pll_c_counters, {n_cnt{default_level(lock_age)}});
      end
   endtask

   // The new high count always differs from the default one
   task automatic divide_reprogram();
      int               h;
      int               l;
      logic [n_cnt-1:0] one_hot;
      div_sel  = int'($urandom % n_cnt);
      div_high = def_high + 1 + int'($urandom % 4);
      div_low  = 1 + int'($urandom % 6);
      one_hot  = '0;
      one_hot[div_sel] = 1'b1;
      send_cmd(divide_word(div_sel, div_high, div_low));
      // Pop latency plus one old period before the new counts are active
      repeat (def_period + 6) @(negedge vco_out);
      measure_counter(div_sel, h, l);
      check_period($sformatf("pll_c_counters[%0d]", div_sel), h, l, div_high, div_low);
      repeat (2 * def_period) begin
         @(negedge vco_out);
         check_counters("pll_c_counters (others)", pll_c_counters & ~one_hot,
                        {n_cnt{default_level(lock_age)}} & ~one_hot);
      end
   endtask

   // Delay is measured modulo the default period of both counters
   task automatic phase_shift();
      int up_steps;
      int dn_steps;
      int d;
      ph_sel   = (div_sel + 1) % n_cnt;
      ref_sel  = (div_sel + 2) % n_cnt;
      up_steps = 1 + int'($urandom % 3);
      dn_steps = 1 + int'($urandom % 3);
      rise_delay(ph_sel, ref_sel, d);
      check_delay("rise delay before shift", d, 0);
      send_cmd(phase_word(ph_sel, 1'b1, up_steps));
      wait_phase_done();
      exp_delay = up_steps % def_period;
      rise_delay(ph_sel, ref_sel, d);
      check_delay("rise delay after up shift", d, exp_delay);
      send_cmd(phase_word(ph_sel, 1'b0, dn_steps));
      wait_phase_done();
      exp_delay = ((exp_delay - dn_steps) % def_period + def_period) % def_period;
      rise_delay(ph_sel, ref_sel, d);
      check_delay("rise delay after down shift", d, exp_delay);
   endtask

   task automatic illegal_commands();
      cfg_word_u bad [4];
      int        d;
      int        h;
      int        l;
      bad[0] = divide_word(5, 3, 3);
      bad[1] = divide_word(ref_sel, 0, 2);
      bad[2] = divide_word(ref_sel, 2, 0);
      bad[3] = phase_word(7, 1'b1, 3);
      for (int i = 0; i < 4; i++) begin
         send_cmd(bad[i]);
         check_bit("cfg_error", cfg_error, 1'b1);
         check_bit("cfg_overflow", cfg_overflow, 1'b0);
         @(negedge vco_out);
         check_bit("cfg_error", cfg_error, 1'b0);
      end
      // Nothing may have reached the bank, so all three test counters look as before
      repeat (2 * def_period) begin
         @(negedge vco_out);
         check_bit("pll_c_counters[ref]", pll_c_counters[ref_sel], default_level(lock_age));
      end
      rise_delay(ph_sel, ref_sel, d);
      check_delay("rise delay after illegal commands", d, exp_delay);
      measure_counter(div_sel, h, l);
      check_period($sformatf("pll_c_counters[%0d]", div_sel), h, l, div_high, div_low);
   endtask

   // Two divides to counter 0 show the order, the fifth word targets counter 3
   task automatic queue_back_pressure();
      cfg_word_u words [5];
      int        exp_h [n_cnt];
      int        exp_l [n_cnt];
      int        h;
      int        l;
      int        n;
      words[0] = divide_word(0, 1, 3);
      words[1] = divide_word(0, 3, 3);
      words[2] = divide_word(1, 4, 2);
      words[3] = divide_word(2, 1, 1);
      words[4] = divide_word(3, 5, 5);
      exp_h    = '{3, 4, 1, def_high, def_high};
      exp_l    = '{3, 2, 1, def_low, def_low};
      apply_reset();
      for (int i = 0; i < 5; i++) begin
         send_cmd(words[i]);
         check_bit("cfg_overflow", cfg_overflow, i == `EMIF_PLL_QUEUE_DEPTH);
         check_bit("cfg_error", cfg_error, 1'b0);
      end
      @(negedge vco_out);
      check_bit("cfg_overflow", cfg_overflow, 1'b0);
      n = 0;
      while (!pll_locked && n < 2 * `EMIF_PLL_LOCK_CYCLES) begin
         @(negedge vco_out);
         n++;
      end
      if (!pll_locked) begin
         other_errors++;
         $display("pll_locked did not rise after the second reset");
      end
      repeat (12) @(negedge vco_out);
      for (int i = 0; i < n_cnt; i++) begin
         measure_counter(i, h, l);
         check_period($sformatf("pll_c_counters[%0d]", i), h, l, exp_h[i], exp_l[i]);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      global_reset_n_int = 1'b0;
      cfg_valid          = 1'b0;
      cfg_word           = '0;
      void'($urandom(32'hfa7d_25cd));
      apply_reset();
      lock_after_reset();
      default_division();
      divide_reprogram();
      phase_shift();
      illegal_commands();
      queue_back_pressure();
      $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      #((test_cycles + margin_cycles) * clk_period);
      $display("Watchdog expired after %0d cycles before the tests finished",
               test_cycles + margin_cycles);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/emif_pll_pkg.sv
verilog/pll_lock_detect.sv
verilog/pll_reconfig_decoder.sv
verilog/pll_reconfig_queue.sv
verilog/pll_counter_bank.sv
verilog/emif_pll_top.sv
testbench/emif_pll_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the PLL output stage with its testbench and runs it
# The run counts as passed only if the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f sim.f --top-module emif_pll_tb &&
./obj_dir/Vemif_pll_tb | tee /dev/stderr | grep -q "^Testbench passed$" &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
